/* project.f */
rtl/periph_pkg.sv
rtl/periph_regs.sv
rtl/uart_tx.sv
rtl/spi_master.sv
rtl/periph_top.sv
verif/periph_checker.sv
verif/periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the peripheral testbench with verilator, run it, and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module periph_tb \
  -f project.f \
  -o periph_sim

./obj_dir/periph_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: testbench reported failure"
  exit 1
fi

echo "run_sim: no failure reported"
exit 0

/* verif/periph_tb.sv */
// periph_top testbench with clock, reset, host req/ack driver, uart and spi models and step table
`timescale 1ns/100ps
`default_nettype none

module periph_tb;

  // small bit period so frames stay short in simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int SPI_HALF_DIV = 2;
  localparam int MAX_STEPS    = 32;

  typedef enum int {
    OP_WRITE, OP_WRITE_BP, OP_READ, OP_DIP,
    OP_POLL, OP_UART_CHECK, OP_SPI_CHECK, OP_SPI_REPLY
  } op_e;

  logic                          clk;
  logic                          i_rst_n;
  logic                          i_req;
  logic                          i_we;
  logic [periph_pkg::ADDR_W-1:0] i_addr;
  logic [periph_pkg::DATA_W-1:0] i_wdata;
  logic [periph_pkg::DIP_W-1:0]  i_gpio_dip;
  logic                          i_spi_miso;
  logic                          o_ack;
  logic [periph_pkg::DATA_W-1:0] o_rdata;
  logic [periph_pkg::LED_W-1:0]  o_gpio_led;
  logic                          o_uart_td;
  logic                          o_spi_cs_n;
  logic                          o_spi_sclk;
  logic                          o_spi_mosi;

  // step table with one entry per index
  string                         step_name  [MAX_STEPS];
  op_e                           step_op    [MAX_STEPS];
  logic [periph_pkg::ADDR_W-1:0] step_addr  [MAX_STEPS];
  logic [7:0]                    step_wdata [MAX_STEPS];
  logic [7:0]                    step_exp   [MAX_STEPS];
  logic [7:0]                    step_ser   [MAX_STEPS];
  int                            n_steps;

  int         error_count;
  int         check_count;
  // bytes written to the uart and bytes decoded off the line
  logic [7:0] uart_exp_q [$];
  logic [7:0] uart_rx_q  [$];
  // spi slave reply, byte it shifted in, byte it should have seen
  logic [7:0] spi_reply;
  logic [7:0] spi_mosi_got;
  logic [7:0] spi_exp;

  periph_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .SPI_HALF_DIV (SPI_HALF_DIV)
  ) i_periph_top (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_req      (i_req),
    .i_we       (i_we),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .o_ack      (o_ack),
    .o_rdata    (o_rdata),
    .i_gpio_dip (i_gpio_dip),
    .o_gpio_led (o_gpio_led),
    .o_uart_td  (o_uart_td),
    .o_spi_cs_n (o_spi_cs_n),
    .o_spi_sclk (o_spi_sclk),
    .o_spi_mosi (o_spi_mosi),
    .i_spi_miso (i_spi_miso)
  );

  // 10 ns clock
  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  // four-phase cycle where latency counts edges from req until ack is seen
  task automatic host_access(input logic we, input logic [periph_pkg::ADDR_W-1:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata,
                             output int latency);
    @(posedge clk);
    i_req   <= 1'b1;
    i_we    <= we;
    i_addr  <= addr;
    i_wdata <= wdata;
    latency = 0;
    do begin
      @(posedge clk);
      latency++;
    end while (o_ack !== 1'b1);
    // read data is valid while ack is high
    rdata = o_rdata;
    i_req <= 1'b0;
    do begin
      @(posedge clk);
    end while (o_ack !== 1'b0);
  endtask

  task automatic add_step(input string name, input op_e op,
                          input logic [periph_pkg::ADDR_W-1:0] addr, input logic [7:0] wdata,
                          input logic [7:0] expected, input logic [7:0] serial);
    step_name[n_steps]  = name;
    step_op[n_steps]    = op;
    step_addr[n_steps]  = addr;
    step_wdata[n_steps] = wdata;
    step_exp[n_steps]   = expected;
    step_ser[n_steps]   = serial;
    n_steps++;
  endtask

  task automatic build_table();
    // reset values
    add_step("led_reset", OP_READ, periph_pkg::ADDR_GPIO_OUT, 8'h00, 8'h00, 8'h00);
    add_step("cs_reset", OP_READ, periph_pkg::ADDR_SPI_CS, 8'h00, 8'h01, 8'h00);
    // leds and switches
    add_step("led_wr_a", OP_WRITE, periph_pkg::ADDR_GPIO_OUT, 8'hA5, 8'h00, 8'h00);
    add_step("led_rd_a", OP_READ, periph_pkg::ADDR_GPIO_OUT, 8'h00, 8'hA5, 8'h00);
    add_step("led_wr_b", OP_WRITE, periph_pkg::ADDR_GPIO_OUT, 8'h3C, 8'h00, 8'h00);
    add_step("led_rd_b", OP_READ, periph_pkg::ADDR_GPIO_OUT, 8'h00, 8'h3C, 8'h00);
    add_step("dip_a", OP_DIP, periph_pkg::ADDR_GPIO_IN, 8'h00, 8'h00, 8'h00);
    add_step("dip_b", OP_DIP, periph_pkg::ADDR_GPIO_IN, 8'h00, 8'h00, 8'h00);
    // second uart byte lands while the first is on the line
    add_step("uart_a", OP_WRITE, periph_pkg::ADDR_UART_DATA, 8'h55, 8'h00, 8'h55);
    add_step("status_busy", OP_READ, periph_pkg::ADDR_STATUS, 8'h00, 8'h01, 8'h00);
    add_step("uart_b", OP_WRITE_BP, periph_pkg::ADDR_UART_DATA, 8'hC3, 8'h00, 8'hC3);
    add_step("uart_rx_ab", OP_UART_CHECK, periph_pkg::ADDR_STATUS, 8'h00, 8'h00, 8'h00);
    add_step("uart_c", OP_WRITE, periph_pkg::ADDR_UART_DATA, 8'h0F, 8'h00, 8'h0F);
    add_step("uart_rx_c", OP_UART_CHECK, periph_pkg::ADDR_STATUS, 8'h00, 8'h00, 8'h00);
    // one spi exchange under chip select
    add_step("cs_low", OP_WRITE, periph_pkg::ADDR_SPI_CS, 8'h00, 8'h00, 8'h00);
    add_step("spi_tx", OP_WRITE, periph_pkg::ADDR_SPI_DATA, 8'h9A, 8'h00, 8'h9A);
    add_step("spi_poll", OP_POLL, periph_pkg::ADDR_STATUS, 8'h02, 8'h00, 8'h00);
    add_step("spi_mosi", OP_SPI_CHECK, periph_pkg::ADDR_SPI_DATA, 8'h00, 8'h00, 8'h00);
    add_step("spi_reply", OP_SPI_REPLY, periph_pkg::ADDR_SPI_DATA, 8'h00, 8'h00, 8'h00);
    add_step("cs_high", OP_WRITE, periph_pkg::ADDR_SPI_CS, 8'h01, 8'h00, 8'h00);
    add_step("cs_rd", OP_READ, periph_pkg::ADDR_SPI_CS, 8'h00, 8'h01, 8'h00);
    // unused codes 6 and 7, write data differs from both led and chip select
    add_step("unused_rd", OP_READ, 3'd6, 8'h00, 8'h00, 8'h00);
    add_step("unused_wr", OP_WRITE, 3'd7, 8'hC2, 8'h00, 8'h00);
    add_step("led_after", OP_READ, periph_pkg::ADDR_GPIO_OUT, 8'h00, 8'h3C, 8'h00);
    add_step("cs_after", OP_READ, periph_pkg::ADDR_SPI_CS, 8'h00, 8'h01, 8'h00);
    add_step("status_idle", OP_READ, periph_pkg::ADDR_STATUS, 8'h00, 8'h00, 8'h00);
  endtask

  task automatic run_step(input int i);
    logic [7:0] rdata;
    logic [3:0] dip_val;
    int         latency;
    case (step_op[i])
      OP_WRITE, OP_WRITE_BP: begin
        // new slave reply each time chip select goes low
        if (step_addr[i] == periph_pkg::ADDR_SPI_CS && !step_wdata[i][0]) begin
          spi_reply = 8'($urandom);
        end
        host_access(1'b1, step_addr[i], step_wdata[i], rdata, latency);
        if (step_addr[i] == periph_pkg::ADDR_GPIO_OUT) begin
          compare_byte({step_name[i], "_pins"}, step_wdata[i], o_gpio_led);
        end
        if (step_addr[i] == periph_pkg::ADDR_SPI_CS) begin
          compare_byte({step_name[i], "_pin"}, {7'b0, step_wdata[i][0]}, {7'b0, o_spi_cs_n});
        end
        if (step_addr[i] == periph_pkg::ADDR_UART_DATA) begin
          uart_exp_q.push_back(step_ser[i]);
        end
        if (step_addr[i] == periph_pkg::ADDR_SPI_DATA) begin
          spi_exp = step_ser[i];
        end
        // held off until the running frame ends
        if (step_op[i] == OP_WRITE_BP) begin
          check_count++;
          assert (latency > CLKS_PER_BIT) else begin
            error_count++;
            $display("FAILED %s: expected ack latency above %0d cycles, actual %0d",
                     step_name[i], CLKS_PER_BIT, latency);
          end
        end
      end
      OP_READ: begin
        host_access(1'b0, step_addr[i], 8'h00, rdata, latency);
        compare_byte(step_name[i], step_exp[i], rdata);
      end
      OP_DIP: begin
        dip_val = 4'($urandom);
        @(posedge clk);
        i_gpio_dip <= dip_val;
        // past the two synchronizer flops
        repeat (3) @(posedge clk);
        host_access(1'b0, step_addr[i], 8'h00, rdata, latency);
        compare_byte(step_name[i], {4'b0000, dip_val}, rdata);
      end
      OP_POLL: begin
        do begin
          host_access(1'b0, step_addr[i], 8'h00, rdata, latency);
        end while ((rdata & step_wdata[i]) != 8'h00);
      end
      OP_UART_CHECK: begin
        while (uart_rx_q.size() < uart_exp_q.size()) begin
          @(posedge clk);
        end
        // in write order
        while (uart_exp_q.size() > 0) begin
          compare_byte(step_name[i], uart_exp_q.pop_front(), uart_rx_q.pop_front());
        end
      end
      OP_SPI_CHECK: begin
        compare_byte(step_name[i], spi_exp, spi_mosi_got);
      end
      OP_SPI_REPLY: begin
        host_access(1'b0, step_addr[i], 8'h00, rdata, latency);
        compare_byte(step_name[i], spi_reply, rdata);
      end
    endcase
  endtask

  // serial receiver sampling every bit at mid period
  initial begin : uart_rx_model
    logic [7:0] rx_byte;
    rx_byte = 8'h00;
    forever begin
      @(posedge clk);
      if (i_rst_n === 1'b1 && o_uart_td === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        check_count++;
        assert (o_uart_td === 1'b0) else begin
          error_count++;
          $display("uart start bit ended before its middle");
        end
        for (int b = 0; b < 8; b++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          rx_byte[b] = o_uart_td;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        check_count++;
        assert (o_uart_td === 1'b1) else begin
          error_count++;
          $display("uart stop bit was low");
        end
        uart_rx_q.push_back(rx_byte);
      end
    end
  end

  // mode-0 sd card side with edges found by comparing against the last cycle
  initial begin : spi_slave_model
    logic       sclk_q;
    logic       cs_q;
    logic [7:0] miso_sh;
    sclk_q = 1'b0;
    cs_q   = 1'b1;
    miso_sh = 8'h00;
    spi_mosi_got = 8'h00;
    i_spi_miso <= 1'b0;
    forever begin
      @(posedge clk);
      if (cs_q && !o_spi_cs_n) begin
        // first reply bit out as soon as cs falls
        miso_sh = spi_reply;
        i_spi_miso <= spi_reply[7];
      end else if (!o_spi_cs_n) begin
        if (!sclk_q && o_spi_sclk) begin
          spi_mosi_got = {spi_mosi_got[6:0], o_spi_mosi};
        end
        if (sclk_q && !o_spi_sclk) begin
          miso_sh = miso_sh << 1;
          i_spi_miso <= miso_sh[7];
        end
      end
      sclk_q = o_spi_sclk;
      cs_q   = o_spi_cs_n;
    end
  end

  // run limit scales with the table, which is built before reset ends
  initial begin : watchdog
    wait (i_rst_n === 1'b1);
    repeat (n_steps * (12 * CLKS_PER_BIT + 50)) @(posedge clk);
    $display("timeout: the step table did not finish in %0d cycles",
             n_steps * (12 * CLKS_PER_BIT + 50));
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main_sequence
    i_rst_n    <= 1'b0;
    i_req      <= 1'b0;
    i_we       <= 1'b0;
    i_addr     <= '0;
    i_wdata    <= '0;
    i_gpio_dip <= '0;
    error_count = 0;
    check_count = 0;
    spi_reply   = 8'h00;
    spi_exp     = 8'h00;
    void'($urandom(44));
    build_table();
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    @(posedge clk);
    // idle pin levels with the uart line in bit 0 and chip select in bit 1
    compare_byte("reset_leds", 8'h00, o_gpio_led);
    compare_byte("reset_lines", 8'h03,
                 {3'b000, o_ack, o_spi_mosi, o_spi_sclk, o_spi_cs_n, o_uart_td});
    for (int i = 0; i < n_steps; i++) begin
      run_step(i);
    end
    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/periph_checker.sv */
// concurrent assertions on req/ack, engine starts and idle serial line levels, and their binds
`timescale 1ns/100ps
`default_nettype none

module periph_checker (
  input wire logic       clk,
  input wire logic       i_rst_n,
  input wire logic       i_req,
  input wire logic       i_ack,
  input wire logic       i_uart_start,
  input wire logic       i_uart_busy,
  input wire logic       i_spi_start,
  input wire logic       i_spi_busy,
  input wire logic [1:0] i_uart_state,
  input wire logic       i_td,
  input wire logic [1:0] i_spi_state,
  input wire logic       i_sclk
);

  // ack only answers a request
  ack_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    (!i_ack && !i_req) |=> !i_ack)
    else $error("ack rose with no request pending");

  // release one edge after req drops
  ack_release: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_ack && !i_req) |=> !i_ack)
    else $error("ack still high one cycle after req fell");

  uart_start_free: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_uart_start |-> !i_uart_busy)
    else $error("uart start pulse while the transmitter was busy");

  spi_start_free: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_spi_start |-> !i_spi_busy)
    else $error("spi start pulse while the shifter was busy");

  // idle line levels
  td_idle_high: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_uart_state == periph_pkg::UART_IDLE) |-> i_td)
    else $error("uart line low while the transmitter was idle");

  sclk_idle_low: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_spi_state == periph_pkg::SPI_IDLE) |-> !i_sclk)
    else $error("spi clock high while the shifter was idle");

endmodule

// handshake and start pulses at the register block
bind periph_regs periph_checker i_regs_checker (
  .clk (clk), .i_rst_n (i_rst_n), .i_req (i_req), .i_ack (o_ack),
  .i_uart_start (o_uart_start), .i_uart_busy (i_uart_busy),
  .i_spi_start (o_spi_start), .i_spi_busy (i_spi_busy),
  .i_uart_state (periph_pkg::UART_IDLE), .i_td (1'b1),
  .i_spi_state (periph_pkg::SPI_IDLE), .i_sclk (1'b0)
);

bind uart_tx periph_checker i_uart_checker (
  .clk (clk), .i_rst_n (i_rst_n), .i_req (1'b0), .i_ack (1'b0),
  .i_uart_start (1'b0), .i_uart_busy (1'b0), .i_spi_start (1'b0), .i_spi_busy (1'b0),
  .i_uart_state (state), .i_td (o_td),
  .i_spi_state (periph_pkg::SPI_IDLE), .i_sclk (1'b0)
);

bind spi_master periph_checker i_spi_checker (
  .clk (clk), .i_rst_n (i_rst_n), .i_req (1'b0), .i_ack (1'b0),
  .i_uart_start (1'b0), .i_uart_busy (1'b0), .i_spi_start (1'b0), .i_spi_busy (1'b0),
  .i_uart_state (periph_pkg::UART_IDLE), .i_td (1'b1),
  .i_spi_state (state), .i_sclk (o_sclk)
);

`default_nettype wire

/* rtl/periph_top.sv */
// peripheral top: register block, uart transmitter and spi master
`timescale 1ns/100ps
`default_nettype none

module periph_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int SPI_HALF_DIV = 4
) (
  input  wire logic                          clk,
  input  wire logic                          i_rst_n,
  // host register port
  input  wire logic                          i_req,
  input  wire logic                          i_we,
  input  wire logic [periph_pkg::ADDR_W-1:0] i_addr,
  input  wire logic [periph_pkg::DATA_W-1:0] i_wdata,
  output logic                               o_ack,
  output logic      [periph_pkg::DATA_W-1:0] o_rdata,
  // board pins
  input  wire logic [periph_pkg::DIP_W-1:0]  i_gpio_dip,
  output logic      [periph_pkg::LED_W-1:0]  o_gpio_led,
  output logic                               o_uart_td,
  output logic                               o_spi_cs_n,
  output logic                               o_spi_sclk,
  output logic                               o_spi_mosi,
  input  wire logic                          i_spi_miso
);

  // register block to engines
  logic                          uart_start;
  logic [periph_pkg::DATA_W-1:0] uart_byte;
  logic                          uart_busy;
  logic                          spi_start;
  logic [periph_pkg::DATA_W-1:0] spi_byte;
  logic                          spi_busy;
  logic [periph_pkg::DATA_W-1:0] spi_rx_byte;

  periph_regs i_periph_regs (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_req         (i_req),
    .i_we          (i_we),
    .i_addr        (i_addr),
    .i_wdata       (i_wdata),
    .o_ack         (o_ack),
    .o_rdata       (o_rdata),
    .i_gpio_dip    (i_gpio_dip),
    .o_gpio_led    (o_gpio_led),
    .i_uart_busy   (uart_busy),
    .o_uart_start  (uart_start),
    .o_uart_byte   (uart_byte),
    .i_spi_busy    (spi_busy),
    .i_spi_rx_byte (spi_rx_byte),
    .o_spi_start   (spi_start),
    .o_spi_byte    (spi_byte),
    .o_spi_cs_n    (o_spi_cs_n)
  );

  // console transmitter
  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (uart_start),
    .i_byte  (uart_byte),
    .o_td    (o_uart_td),
    .o_busy  (uart_busy)
  );

  // sd card shifter with chip select held in the register block
  spi_master #(
    .SPI_HALF_DIV (SPI_HALF_DIV)
  ) i_spi_master (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_start   (spi_start),
    .i_byte    (spi_byte),
    .i_miso    (i_spi_miso),
    .o_sclk    (o_spi_sclk),
    .o_mosi    (o_spi_mosi),
    .o_busy    (spi_busy),
    .o_rx_byte (spi_rx_byte)
  );

endmodule

`default_nettype wire

/* rtl/spi_master.sv */
// mode-0 spi byte shifter, msb first, with half-period clock divider
`timescale 1ns/100ps
`default_nettype none

module spi_master #(
  parameter int SPI_HALF_DIV = 4
) (
  input  wire logic                          clk,
  input  wire logic                          i_rst_n,
  input  wire logic                          i_start,
  input  wire logic [periph_pkg::DATA_W-1:0] i_byte,
  input  wire logic                          i_miso,
  output logic                               o_sclk,
  output logic                               o_mosi,
  output logic                               o_busy,
  output logic      [periph_pkg::DATA_W-1:0] o_rx_byte
);

  localparam int DIV_W = (SPI_HALF_DIV > 1) ? $clog2(SPI_HALF_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_HALF_DIV - 1);

  periph_pkg::spi_state_e        state;
  logic [DIV_W-1:0]              div_cnt;
  logic [2:0]                    bit_idx;
  logic [periph_pkg::DATA_W-1:0] tx_q;
  logic [periph_pkg::DATA_W-1:0] rx_q;
  logic                          half_end;
  logic                          start_go;
  logic                          sclk_rise;
  logic                          sclk_fall;
  logic                          last_bit;

  assign half_end  = (div_cnt == DIV_LAST);
  assign start_go  = (state == periph_pkg::SPI_IDLE) && i_start;
  // sample point and shift point of mode 0
  assign sclk_rise = (state == periph_pkg::SPI_LOW) && half_end;
  assign sclk_fall = (state == periph_pkg::SPI_HIGH) && half_end;
  assign last_bit  = (bit_idx == 3'd7);
  assign o_busy    = (state != periph_pkg::SPI_IDLE);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= periph_pkg::SPI_IDLE;
      div_cnt <= '0;
      bit_idx <= '0;
      o_sclk  <= 1'b0;
      o_mosi  <= 1'b0;
    end else begin
      if (state == periph_pkg::SPI_IDLE || half_end) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (start_go) begin
        // first bit set up one cycle after start while sclk stays low
        state   <= periph_pkg::SPI_LOW;
        bit_idx <= '0;
        o_mosi  <= i_byte[periph_pkg::DATA_W-1];
      end else if (sclk_rise) begin
        state  <= periph_pkg::SPI_HIGH;
        o_sclk <= 1'b1;
      end else if (sclk_fall) begin
        o_sclk <= 1'b0;
        if (last_bit) begin
          // byte done and both lines back to idle low
          state  <= periph_pkg::SPI_IDLE;
          o_mosi <= 1'b0;
        end else begin
          state   <= periph_pkg::SPI_LOW;
          bit_idx <= bit_idx + 1'b1;
          o_mosi  <= tx_q[periph_pkg::DATA_W-2];
        end
      end
    end
  end

  // shift registers and received byte
  always_ff @(posedge clk) begin
    if (start_go) begin
      tx_q <= i_byte;
    end else if (sclk_fall) begin
      tx_q <= tx_q << 1;
    end
    if (sclk_rise) begin
      rx_q <= {rx_q[periph_pkg::DATA_W-2:0], i_miso};
    end
    // all 8 bits in by the last rising edge
    if (sclk_fall && last_bit) begin
      o_rx_byte <= rx_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
// 8N1 serial transmitter with bit-period counter and bit index
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  wire logic                          clk,
  input  wire logic                          i_rst_n,
  input  wire logic                          i_start,
  input  wire logic [periph_pkg::DATA_W-1:0] i_byte,
  output logic                               o_td,
  output logic                               o_busy
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  periph_pkg::uart_state_e       state;
  logic [CNT_W-1:0]              bit_cnt;
  logic [2:0]                    bit_idx;
  logic [periph_pkg::DATA_W-1:0] data_q;
  logic                          bit_end;
  logic                          start_go;

  // end of the current bit period
  assign bit_end  = (bit_cnt == CNT_LAST);
  assign start_go = (state == periph_pkg::UART_IDLE) && i_start;
  assign o_busy   = (state != periph_pkg::UART_IDLE);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= periph_pkg::UART_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      o_td    <= 1'b1;
    end else begin
      // period counter runs in every non-idle state
      if (state == periph_pkg::UART_IDLE || bit_end) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      case (state)
        periph_pkg::UART_IDLE: begin
          o_td <= 1'b1;
          if (i_start) begin
            // start bit on the next cycle
            state <= periph_pkg::UART_START;
            o_td  <= 1'b0;
          end
        end
        periph_pkg::UART_START: begin
          if (bit_end) begin
            state   <= periph_pkg::UART_DATA;
            bit_idx <= '0;
            o_td    <= data_q[0];
          end
        end
        periph_pkg::UART_DATA: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              // stop bit
              state <= periph_pkg::UART_STOP;
              o_td  <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              o_td    <= data_q[1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= periph_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first with one right shift per data bit
  always_ff @(posedge clk) begin
    if (start_go) begin
      data_q <= i_byte;
    end else if (state == periph_pkg::UART_DATA && bit_end) begin
      data_q <= data_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* rtl/periph_regs.sv */
// register decoder with four-phase req/ack, gpio registers, dip synchronizer and engine starts
`timescale 1ns/100ps
`default_nettype none

module periph_regs (
  input  wire logic                          clk,
  input  wire logic                          i_rst_n,
  // host side, four-phase handshake
  input  wire logic                          i_req,
  input  wire logic                          i_we,
  input  wire logic [periph_pkg::ADDR_W-1:0] i_addr,
  input  wire logic [periph_pkg::DATA_W-1:0] i_wdata,
  output logic                               o_ack,
  output logic      [periph_pkg::DATA_W-1:0] o_rdata,
  // gpio pins
  input  wire logic [periph_pkg::DIP_W-1:0]  i_gpio_dip,
  output logic      [periph_pkg::LED_W-1:0]  o_gpio_led,
  // uart engine
  input  wire logic                          i_uart_busy,
  output logic                               o_uart_start,
  output logic      [periph_pkg::DATA_W-1:0] o_uart_byte,
  // spi engine
  input  wire logic                          i_spi_busy,
  input  wire logic [periph_pkg::DATA_W-1:0] i_spi_rx_byte,
  output logic                               o_spi_start,
  output logic      [periph_pkg::DATA_W-1:0] o_spi_byte,
  output logic                               o_spi_cs_n
);

  periph_pkg::reg_addr_e               addr;
  logic [periph_pkg::DIP_W-1:0]        dip_meta;
  logic [periph_pkg::DIP_W-1:0]        dip_sync;
  logic                                wr_uart;
  logic                                wr_spi;
  logic                                ready;
  logic                                accept;
  logic [periph_pkg::DATA_W-1:0]       rd_mux;

  // raw address onto the register map so unused codes fall to default
  assign addr = periph_pkg::reg_addr_e'(i_addr);

  assign wr_uart = i_we && (addr == periph_pkg::ADDR_UART_DATA);
  assign wr_spi  = i_we && (addr == periph_pkg::ADDR_SPI_DATA);

  // hold off a start while that engine is still busy
  assign ready = !(wr_uart && i_uart_busy) && !(wr_spi && i_spi_busy);

  // new request only once ack is low and the previous cycle has closed
  assign accept = i_req && !o_ack && ready;

  // read data selection
  always_comb begin
    rd_mux = '0;
    case (addr)
      periph_pkg::ADDR_GPIO_OUT: rd_mux = o_gpio_led;
      periph_pkg::ADDR_GPIO_IN:  rd_mux = {{(periph_pkg::DATA_W - periph_pkg::DIP_W){1'b0}},
                                          dip_sync};
      periph_pkg::ADDR_STATUS:   rd_mux = {{(periph_pkg::DATA_W - 2){1'b0}},
                                          i_spi_busy, i_uart_busy};
      periph_pkg::ADDR_SPI_DATA: rd_mux = i_spi_rx_byte;
      periph_pkg::ADDR_SPI_CS:   rd_mux = {{(periph_pkg::DATA_W - 1){1'b0}}, o_spi_cs_n};
      // uart data is write only
      default:                   rd_mux = '0;
    endcase
  end

  // ack rises on accept and follows req back down
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ack <= 1'b0;
    end else if (o_ack) begin
      o_ack <= i_req;
    end else begin
      o_ack <= accept;
    end
  end

  // one-cycle start pulses at the accepting edge
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_uart_start <= 1'b0;
      o_spi_start  <= 1'b0;
    end else begin
      o_uart_start <= accept && wr_uart;
      o_spi_start  <= accept && wr_spi;
    end
  end

  // led and chip select registers
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_gpio_led <= '0;
      o_spi_cs_n <= 1'b1;
    end else if (accept && i_we) begin
      if (addr == periph_pkg::ADDR_GPIO_OUT) begin
        o_gpio_led <= i_wdata[periph_pkg::LED_W-1:0];
      end
      if (addr == periph_pkg::ADDR_SPI_CS) begin
        o_spi_cs_n <= i_wdata[0];
      end
    end
  end

  // outgoing bytes and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      o_rdata <= rd_mux;
      if (wr_uart) begin
        o_uart_byte <= i_wdata;
      end
      if (wr_spi) begin
        o_spi_byte <= i_wdata;
      end
    end
  end

  // two flops on the switch inputs
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dip_meta <= '0;
      dip_sync <= '0;
    end else begin
      dip_meta <= i_gpio_dip;
      dip_sync <= dip_meta;
    end
  end

endmodule

`default_nettype wire

/* rtl/periph_pkg.sv */
// shared data widths, register address map and serial engine state encodings
`default_nettype none

package periph_pkg;

  // register port widths
  localparam int DATA_W = 8;
  localparam int ADDR_W = 3;

  // leds out and dip switches in
  localparam int LED_W = 8;
  localparam int DIP_W = 4;

  // register map
  // 6 and 7 are unused, read zero and drop writes
  typedef enum logic [ADDR_W-1:0] {
    ADDR_GPIO_OUT  = 3'd0,
    ADDR_GPIO_IN   = 3'd1,
    ADDR_UART_DATA = 3'd2,
    ADDR_STATUS    = 3'd3,
    ADDR_SPI_DATA  = 3'd4,
    ADDR_SPI_CS    = 3'd5
  } reg_addr_e;

  // 8N1 transmitter framing states
  typedef enum logic [1:0] {
    UART_IDLE  = 2'd0,
    UART_START = 2'd1,
    UART_DATA  = 2'd2,
    UART_STOP  = 2'd3
  } uart_state_e;

  // mode-0 shifter states for the low and high half of each bit
  typedef enum logic [1:0] {
    SPI_IDLE = 2'd0,
    SPI_LOW  = 2'd1,
    SPI_HIGH = 2'd2
  } spi_state_e;

endpackage

`default_nettype wire
